// File: Bender.yml
package:
  name: mipsCore

sources:
  - include_dirs:
      - logic
    files:
      - logic/mipsPkg.sv
      - logic/instructionFetch.sv
      - logic/instructionDecode.sv
      - logic/execute.sv
      - logic/memoryAccess.sv
      - logic/mipsCore.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/mipsCoreTb.sv

// File: logic/execute.sv
`timescale 1ns/1ps
`include "pipe_config.svh"

module execute (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        stopDebug,
    input  logic [`PIPE_DATA_W-1:0]     exRegA,
    input  logic [`PIPE_DATA_W-1:0]     exRegB,
    input  logic [`PIPE_DATA_W-1:0]     exImmediate,
    input  logic [`PIPE_DATA_W-1:0]     exPcPlus4,
    input  logic [mipsPkg::regIdxW-1:0] exRs,
    input  logic [mipsPkg::regIdxW-1:0] exRt,
    input  logic [mipsPkg::regIdxW-1:0] exDestReg,
    input  mipsPkg::aluOpT              exAluOp,
    input  logic                        exAluSrcImm,
    input  logic                        exMemRead,
    input  logic                        exMemWrite,
    input  logic                        exRegWrite,
    input  logic                        exMemToReg,
    input  logic                        exBranch,
    input  logic                        wbWrite,
    input  logic [mipsPkg::regIdxW-1:0] wbReg,
    input  logic [`PIPE_DATA_W-1:0]     wbData,
    output logic                        branchTake,
    output logic [`PIPE_DATA_W-1:0]     branchTarget,
    output logic [`PIPE_DATA_W-1:0]     aluResult,
    output logic [`PIPE_DATA_W-1:0]     storeData,
    output logic [mipsPkg::regIdxW-1:0] destReg,
    output logic                        memRead,
    output logic                        memWrite,
    output logic                        regWrite,
    output logic                        memToReg
);

    import mipsPkg::*;

    logic [`PIPE_DATA_W-1:0] opA;
    logic [`PIPE_DATA_W-1:0] opB;
    logic [`PIPE_DATA_W-1:0] aluB;
    logic [`PIPE_DATA_W-1:0] aluOut;

    ////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////

    // Youngest producer first, R0 never forwarded
    function automatic logic [`PIPE_DATA_W-1:0] forward(
        input logic [regIdxW-1:0]      idx,
        input logic [`PIPE_DATA_W-1:0] regVal
    );
        if (regWrite && destReg != '0 && destReg == idx) begin
            return aluResult;
        end else if (wbWrite && wbReg != '0 && wbReg == idx) begin
            return wbData;
        end
        return regVal;
    endfunction

    ////////////////////////////////////////
    // ALU and branch
    ////////////////////////////////////////

    always_comb begin
        opA  = forward(exRs, exRegA);
        opB  = forward(exRt, exRegB);
        aluB = exAluSrcImm ? exImmediate : opB;
        case (exAluOp)
            aluAdd:  aluOut = opA + aluB;
            aluSub:  aluOut = opA - aluB;
            aluAnd:  aluOut = opA & aluB;
            aluOr:   aluOut = opA | aluB;
            // Signed compare
            aluSlt:  aluOut = {{(`PIPE_DATA_W-1){1'b0}}, $signed(opA) < $signed(aluB)};
            default: aluOut = opA + aluB;
        endcase
    end

    // BEQ compares the forwarded registers, not the ALU input
    assign branchTake   = exBranch && (opA == opB);
    assign branchTarget = exPcPlus4 + {exImmediate[`PIPE_DATA_W-3:0], 2'b00};

    // EX/MEM register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            aluResult <= '0;
            storeData <= '0;
            destReg   <= '0;
            memRead   <= 1'b0;
            memWrite  <= 1'b0;
            regWrite  <= 1'b0;
            memToReg  <= 1'b0;
        end else if (!stopDebug) begin
            aluResult <= aluOut;
            storeData <= opB;
            destReg   <= exDestReg;
            memRead   <= exMemRead;
            memWrite  <= exMemWrite;
            regWrite  <= exRegWrite;
            memToReg  <= exMemToReg;
        end
    end

endmodule

// File: logic/instructionDecode.sv
`timescale 1ns/1ps
`include "pipe_config.svh"

module instructionDecode (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        stopDebug,
    input  logic                        loadProgram,
    input  logic [`PIPE_DATA_W-1:0]     instruction,
    input  logic [`PIPE_DATA_W-1:0]     pcPlus4,
    input  logic                        branchTake,
    input  logic                        wbWrite,
    input  logic [mipsPkg::regIdxW-1:0] wbReg,
    input  logic [`PIPE_DATA_W-1:0]     wbData,
    input  logic [mipsPkg::regIdxW-1:0] debugRegAddr,
    output logic                        jumpTake,
    output logic [`PIPE_DATA_W-1:0]     jumpTarget,
    output logic                        pcStall,
    output logic [`PIPE_DATA_W-1:0]     debugRegData,
    output logic [`PIPE_DATA_W-1:0]     exRegA,
    output logic [`PIPE_DATA_W-1:0]     exRegB,
    output logic [`PIPE_DATA_W-1:0]     exImmediate,
    output logic [`PIPE_DATA_W-1:0]     exPcPlus4,
    output logic [mipsPkg::regIdxW-1:0] exRs,
    output logic [mipsPkg::regIdxW-1:0] exRt,
    output logic [mipsPkg::regIdxW-1:0] exDestReg,
    output mipsPkg::aluOpT              exAluOp,
    output logic                        exAluSrcImm,
    output logic                        exMemRead,
    output logic                        exMemWrite,
    output logic                        exRegWrite,
    output logic                        exMemToReg,
    output logic                        exBranch
);

    import mipsPkg::*;

    opcodeT                  opcode;
    functT                   funct;
    logic [regIdxW-1:0]      rs;
    logic [regIdxW-1:0]      rt;
    logic [regIdxW-1:0]      rd;
    logic [`PIPE_DATA_W-1:0] immExt;
    logic [`PIPE_DATA_W-1:0] srcA;
    logic [`PIPE_DATA_W-1:0] srcB;
    logic [`PIPE_DATA_W-1:0] regFile [2**regIdxW];

    // Decoded control
    aluOpT              aluOp;
    logic [regIdxW-1:0] destReg;
    logic               aluSrcImm;
    logic               memRead;
    logic               memWrite;
    logic               regWrite;
    logic               memToReg;
    logic               branch;
    logic               jump;
    logic               usesRs;
    logic               usesRt;
    logic               bubble;

    // Instruction fields
    assign opcode = opcodeT'(instruction[31:26]);
    assign funct  = functT'(instruction[5:0]);
    assign rs     = instruction[25:21];
    assign rt     = instruction[20:16];
    assign rd     = instruction[15:11];
    assign immExt = {{(`PIPE_DATA_W-immW){instruction[immW-1]}}, instruction[immW-1:0]};

    // Region bits of the next PC, word index from the J field
    assign jumpTarget = {pcPlus4[`PIPE_DATA_W-1:jumpW+2], instruction[jumpW-1:0], 2'b00};

    ////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////

    always_comb begin
        aluOp     = aluAdd;
        destReg   = rd;
        aluSrcImm = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        regWrite  = 1'b0;
        memToReg  = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        usesRs    = 1'b0;
        usesRt    = 1'b0;
        case (opcode)
            opRType: begin
                usesRs   = 1'b1;
                usesRt   = 1'b1;
                regWrite = 1'b1;
                case (funct)
                    fnAdd:   aluOp = aluAdd;
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    // Unknown function, also the all-zero bubble
                    default: regWrite = 1'b0;
                endcase
            end
            opAddi: begin
                usesRs    = 1'b1;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                destReg   = rt;
            end
            opLw: begin
                usesRs    = 1'b1;
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
                regWrite  = 1'b1;
                memToReg  = 1'b1;
                destReg   = rt;
            end
            opSw: begin
                usesRs    = 1'b1;
                usesRt    = 1'b1;
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
            end
            opBeq: begin
                usesRs = 1'b1;
                usesRt = 1'b1;
                branch = 1'b1;
            end
            opJ:     jump = 1'b1;
            default: jump = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // Register file
    ////////////////////////////////////////

    // R0 hardwired, same-cycle writeback passed straight through
    function automatic logic [`PIPE_DATA_W-1:0] readReg(input logic [regIdxW-1:0] idx);
        if (idx == '0) begin
            return '0;
        end else if (wbWrite && wbReg == idx) begin
            return wbData;
        end
        return regFile[idx];
    endfunction

    always_comb begin
        srcA         = readReg(rs);
        srcB         = readReg(rt);
        debugRegData = readReg(debugRegAddr);
    end

    always_ff @(posedge clk) begin
        if (wbWrite && wbReg != '0 && !stopDebug) begin
            regFile[wbReg] <= wbData;
        end
    end

    ////////////////////////////////////////
    // Hazards and ID/EX
    ////////////////////////////////////////

    // Load in EX feeding a source read here
    assign pcStall = exMemRead && exDestReg != '0 &&
                     ((usesRs && rs == exDestReg) || (usesRt && rt == exDestReg));

    assign jumpTake = jump;

    // Load mode, stall and branch flush all squash the decoded instruction
    assign bubble = loadProgram || pcStall || branchTake;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exRegA      <= '0;
            exRegB      <= '0;
            exImmediate <= '0;
            exPcPlus4   <= '0;
            exRs        <= '0;
            exRt        <= '0;
            exDestReg   <= '0;
            exAluOp     <= aluAdd;
            exAluSrcImm <= 1'b0;
            exMemRead   <= 1'b0;
            exMemWrite  <= 1'b0;
            exRegWrite  <= 1'b0;
            exMemToReg  <= 1'b0;
            exBranch    <= 1'b0;
        end else if (!stopDebug) begin
            exRegA      <= srcA;
            exRegB      <= srcB;
            exImmediate <= immExt;
            exPcPlus4   <= pcPlus4;
            exRs        <= rs;
            exRt        <= rt;
            exDestReg   <= destReg;
            exAluOp     <= aluOp;
            exAluSrcImm <= aluSrcImm;
            // Only the side effects need clearing for a bubble
            exMemRead   <= memRead && !bubble;
            exMemWrite  <= memWrite && !bubble;
            exRegWrite  <= regWrite && !bubble;
            exMemToReg  <= memToReg && !bubble;
            exBranch    <= branch && !bubble;
        end
    end

    // Stall clears after one cycle and never overlaps a jump
    stallOneCycle: assert property (@(posedge clk) disable iff (!arstN)
        pcStall && !stopDebug |-> !jumpTake ##1 !pcStall);

endmodule

// File: logic/instructionFetch.sv
`timescale 1ns/1ps
`include "pipe_config.svh"

module instructionFetch (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                loadProgram,
    input  logic                                programWrite,
    input  logic [$clog2(`PIPE_IMEM_DEPTH)-1:0] programAddress,
    input  logic [`PIPE_DATA_W-1:0]             programData,
    input  logic                                stopDebug,
    input  logic                                pcStall,
    input  logic                                jumpTake,
    input  logic [`PIPE_DATA_W-1:0]             jumpTarget,
    input  logic                                branchTake,
    input  logic [`PIPE_DATA_W-1:0]             branchTarget,
    output logic [`PIPE_DATA_W-1:0]             instruction,
    output logic [`PIPE_DATA_W-1:0]             pcPlus4,
    output logic [`PIPE_DATA_W-1:0]             pcOut
);

    localparam int imemAw = $clog2(`PIPE_IMEM_DEPTH);

    logic [`PIPE_DATA_W-1:0] imem [`PIPE_IMEM_DEPTH];
    logic [`PIPE_DATA_W-1:0] pc;
    logic [`PIPE_DATA_W-1:0] seqPc;
    logic [`PIPE_DATA_W-1:0] redirectPc;
    logic [`PIPE_DATA_W-1:0] fetched;
    logic                    redirect;

    ////////////////////////////////////////
    // Program memory
    ////////////////////////////////////////

    // Loaded word by word while the core is held in load mode
    always_ff @(posedge clk) begin
        if (loadProgram && programWrite && !stopDebug) begin
            imem[programAddress] <= programData;
        end
    end

    // Word index from the byte PC
    assign fetched = imem[pc[imemAw+1:2]];

    ////////////////////////////////////////
    // Next PC
    ////////////////////////////////////////

    assign seqPc = pc + `PIPE_DATA_W'(4);

    // Branch from EX is older than a jump in ID, so it wins
    assign redirectPc = branchTake ? branchTarget : jumpTarget;

    // A jump waits while decode is stalled
    assign redirect = branchTake || (jumpTake && !pcStall);

    // PC and IF/ID register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc          <= '0;
            instruction <= '0;
            pcPlus4     <= '0;
        end else if (!stopDebug) begin
            if (loadProgram) begin
                // Restart from word 0 with an empty pipe
                pc          <= '0;
                instruction <= '0;
                pcPlus4     <= '0;
            end else if (redirect) begin
                // Shadow instruction becomes a bubble
                pc          <= redirectPc;
                instruction <= '0;
                pcPlus4     <= '0;
            end else if (!pcStall) begin
                pc          <= seqPc;
                instruction <= fetched;
                pcPlus4     <= seqPc;
            end
        end
    end

    assign pcOut = pc;

    // Targets from decode and execute must land on word boundaries
    pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00);

endmodule

// File: logic/memoryAccess.sv
`timescale 1ns/1ps
`include "pipe_config.svh"

module memoryAccess (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                stopDebug,
    input  logic [`PIPE_DATA_W-1:0]             aluResult,
    input  logic [`PIPE_DATA_W-1:0]             storeData,
    input  logic [mipsPkg::regIdxW-1:0]         destReg,
    input  logic                                memRead,
    input  logic                                memWrite,
    input  logic                                regWrite,
    input  logic                                memToReg,
    input  logic [$clog2(`PIPE_DMEM_DEPTH)-1:0] debugMemAddr,
    output logic                                wbWrite,
    output logic [mipsPkg::regIdxW-1:0]         wbReg,
    output logic [`PIPE_DATA_W-1:0]             wbData,
    output logic [`PIPE_DATA_W-1:0]             debugMemData
);

    localparam int dmemAw = $clog2(`PIPE_DMEM_DEPTH);

    logic [`PIPE_DATA_W-1:0] dmem [`PIPE_DMEM_DEPTH];
    logic [dmemAw-1:0]       memIndex;
    logic [`PIPE_DATA_W-1:0] wbLoad;
    logic [`PIPE_DATA_W-1:0] wbAlu;
    logic                    wbMemToReg;

    // Word address, byte offset dropped
    assign memIndex = aluResult[dmemAw+1:2];

    always_ff @(posedge clk) begin
        if (memWrite && !stopDebug) begin
            dmem[memIndex] <= storeData;
        end
    end

    assign debugMemData = dmem[debugMemAddr];

    ////////////////////////////////////////
    // MEM/WB and writeback select
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbWrite    <= 1'b0;
            wbReg      <= '0;
            wbLoad     <= '0;
            wbAlu      <= '0;
            wbMemToReg <= 1'b0;
        end else if (!stopDebug) begin
            wbWrite    <= regWrite;
            wbReg      <= destReg;
            wbLoad     <= memRead ? dmem[memIndex] : '0;
            wbAlu      <= aluResult;
            wbMemToReg <= memToReg;
        end
    end

    assign wbData = wbMemToReg ? wbLoad : wbAlu;

    // Upstream EX/MEM freezes too, so the addressed word must hold
    noWriteFrozen: assert property (@(posedge clk) disable iff (!arstN)
        stopDebug |=> $stable(dmem[memIndex]));

endmodule

// File: logic/mipsCore.sv
`timescale 1ns/1ps
`include "pipe_config.svh"

module mipsCore (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                loadProgram,
    input  logic                                programWrite,
    input  logic [$clog2(`PIPE_IMEM_DEPTH)-1:0] programAddress,
    input  logic [`PIPE_DATA_W-1:0]             programData,
    input  logic                                stopDebug,
    input  logic [mipsPkg::regIdxW-1:0]         debugRegAddr,
    input  logic [$clog2(`PIPE_DMEM_DEPTH)-1:0] debugMemAddr,
    output logic [`PIPE_DATA_W-1:0]             pcOut,
    output logic [`PIPE_DATA_W-1:0]             debugRegData,
    output logic [`PIPE_DATA_W-1:0]             debugMemData
);

    import mipsPkg::*;

    // IF/ID
    logic [`PIPE_DATA_W-1:0] instruction;
    logic [`PIPE_DATA_W-1:0] pcPlus4;

    // Redirects and stall back to fetch
    logic                    pcStall;
    logic                    jumpTake;
    logic [`PIPE_DATA_W-1:0] jumpTarget;
    logic                    branchTake;
    logic [`PIPE_DATA_W-1:0] branchTarget;

    // ID/EX
    logic [`PIPE_DATA_W-1:0] exRegA;
    logic [`PIPE_DATA_W-1:0] exRegB;
    logic [`PIPE_DATA_W-1:0] exImmediate;
    logic [`PIPE_DATA_W-1:0] exPcPlus4;
    logic [regIdxW-1:0]      exRs;
    logic [regIdxW-1:0]      exRt;
    logic [regIdxW-1:0]      exDestReg;
    aluOpT                   exAluOp;
    logic                    exAluSrcImm;
    logic                    exMemRead;
    logic                    exMemWrite;
    logic                    exRegWrite;
    logic                    exMemToReg;
    logic                    exBranch;

    // EX/MEM
    logic [`PIPE_DATA_W-1:0] aluResult;
    logic [`PIPE_DATA_W-1:0] storeData;
    logic [regIdxW-1:0]      destReg;
    logic                    memRead;
    logic                    memWrite;
    logic                    regWrite;
    logic                    memToReg;

    // Writeback port, also the second forwarding source
    logic                    wbWrite;
    logic [regIdxW-1:0]      wbReg;
    logic [`PIPE_DATA_W-1:0] wbData;

    // Every port name matches its wire
    instructionFetch  fetchStage  (.*);
    instructionDecode decodeStage (.*);
    execute           execStage   (.*);
    memoryAccess      memStage    (.*);

endmodule

// File: logic/mipsPkg.sv
package mipsPkg;

    // Instruction field widths
    localparam int regIdxW = 5;
    localparam int opcodeW = 6;
    localparam int functW  = 6;
    localparam int immW    = 16;
    localparam int jumpW   = 26;

    // Primary opcode, instruction bits 31:26
    typedef enum logic [opcodeW-1:0] {
        opRType = 6'h00,
        opJ     = 6'h02,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeT;

    // R-type function field, bits 5:0
    typedef enum logic [functW-1:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functT;

    // Operations carried from decode to the ALU
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOpT;

endpackage

// File: logic/pipe_config.svh
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// Datapath and register width
`define PIPE_DATA_W 32

// Instruction memory, in 32-bit words
`define PIPE_IMEM_DEPTH 64

// Data memory, in 32-bit words
`define PIPE_DMEM_DEPTH 64

`endif

// File: project.f
+incdir+logic
logic/mipsPkg.sv
logic/instructionFetch.sv
logic/instructionDecode.sv
logic/execute.sv
logic/memoryAccess.sv
logic/mipsCore.sv
verif/mipsCoreTb.sv

// File: verif/mipsCoreTb.sv
`timescale 1ns/1ps
`include "pipe_config.svh"

module mipsCoreTb;

    import mipsPkg::*;

    localparam int imemAw = $clog2(`PIPE_IMEM_DEPTH);
    localparam int dmemAw = $clog2(`PIPE_DMEM_DEPTH);

    // Run budget from the largest program and the number of loads
    localparam int resetCycles   = 5;
    localparam int freezeCycles  = 20;
    localparam int programCount  = 14;
    localparam int maxWords      = 16;
    localparam int checksPerProg = 10;
    localparam int cycleLimit    = resetCycles + freezeCycles + 200 +
                                   programCount * (4 * maxWords + 14 + 2 * checksPerProg);

    logic                    clk;
    logic                    arstN;
    logic                    loadProgram;
    logic                    programWrite;
    logic [imemAw-1:0]       programAddress;
    logic [`PIPE_DATA_W-1:0] programData;
    logic                    stopDebug;
    logic [regIdxW-1:0]      debugRegAddr;
    logic [dmemAw-1:0]       debugMemAddr;
    logic [`PIPE_DATA_W-1:0] pcOut;
    logic [`PIPE_DATA_W-1:0] debugRegData;
    logic [`PIPE_DATA_W-1:0] debugMemData;

    // Program image under construction
    logic [`PIPE_DATA_W-1:0] prog [$];
    int unsigned             cycleCount;

    mipsCore DUT (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    ////////////////////////////////////////
    // Failure and timeout
    ////////////////////////////////////////

    task automatic abortRun();
        $display("Test failed");
        $fatal(1, "Stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
            abortRun();
        end
    end

    ////////////////////////////////////////
    // Program builder
    ////////////////////////////////////////

    function automatic logic [31:0] signExt16(input logic [15:0] value);
        return {{16{value[15]}}, value};
    endfunction

    task automatic clearProgram();
        prog.delete();
    endtask

    // rd = rs op rt
    task automatic emitR(input functT fn, input logic [4:0] rd, input logic [4:0] rs,
                         input logic [4:0] rt);
        prog.push_back({6'(opRType), rs, rt, rd, 5'd0, 6'(fn)});
    endtask

    // Operands in assembly order rt, rs and immediate
    task automatic emitI(input opcodeT op, input logic [4:0] rt, input logic [4:0] rs,
                         input logic [15:0] imm);
        prog.push_back({6'(op), rs, rt, imm});
    endtask

    // Target is a word index
    task automatic emitJ(input int unsigned word);
        prog.push_back({6'(opJ), 26'(word)});
    endtask

    task automatic emitSelfJump();
        emitJ(prog.size());
    endtask

    ////////////////////////////////////////
    // Load, run and debug reads
    ////////////////////////////////////////

    // Hold load mode and write one word per cycle
    task automatic loadImage();
        @(posedge clk);
        loadProgram <= 1'b1;
        stopDebug   <= 1'b0;
        foreach (prog[i]) begin
            @(posedge clk);
            programWrite   <= 1'b1;
            programAddress <= imemAw'(i);
            programData    <= prog[i];
        end
        @(posedge clk);
        programWrite <= 1'b0;
        @(posedge clk);
        loadProgram <= 1'b0;
        // Fetch restarts from word 0 once load mode ends
        @(negedge clk);
        assert (pcOut === 32'd0) else begin
            $display("[FAIL] pcOut after load: got 0x%h, expected 0x%h", pcOut, 32'd0);
            abortRun();
        end
    endtask

    task automatic runCycles(input int unsigned count);
        repeat (count) @(posedge clk);
    endtask

    task automatic freezeCore();
        @(posedge clk);
        stopDebug <= 1'b1;
    endtask

    // Three cycles per word covers stalls and redirects
    task automatic executeProgram();
        loadImage();
        runCycles(3 * prog.size() + 10);
        freezeCore();
    endtask

    task automatic checkReg(input logic [4:0] idx, input logic [31:0] expected);
        @(posedge clk);
        stopDebug    <= 1'b1;
        debugRegAddr <= idx;
        @(negedge clk);
        assert (debugRegData === expected) else begin
            $display("[FAIL] debugRegData (r%0d): got 0x%h, expected 0x%h",
                     idx, debugRegData, expected);
            abortRun();
        end
    endtask

    task automatic checkMem(input logic [dmemAw-1:0] idx, input logic [31:0] expected);
        @(posedge clk);
        stopDebug    <= 1'b1;
        debugMemAddr <= idx;
        @(negedge clk);
        assert (debugMemData === expected) else begin
            $display("[FAIL] debugMemData (word %0d): got 0x%h, expected 0x%h",
                     idx, debugMemData, expected);
            abortRun();
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    // Dependent chain over both forwarding paths and the R0 rule
    task automatic testAluChain();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sum;
        logic [31:0] diff;
        logic [31:0] conj;
        a = signExt16(16'd7);
        b = signExt16(16'hfffd);
        sum  = a + b;
        diff = sum - a;
        conj = diff & sum;
        clearProgram();
        emitI(opAddi, 1, 0, 16'd7);
        emitI(opAddi, 2, 0, 16'hfffd);
        emitR(fnAdd, 3, 1, 2);
        emitR(fnSub, 4, 3, 1);
        emitR(fnAnd, 5, 4, 3);
        emitR(fnOr, 6, 5, 2);
        emitR(fnSlt, 7, 2, 1);
        emitR(fnSlt, 8, 1, 2);
        emitI(opAddi, 0, 0, 16'h0055);
        emitR(fnAdd, 9, 0, 1);
        emitSelfJump();
        executeProgram();
        checkReg(3, sum);
        checkReg(4, diff);
        checkReg(5, conj);
        checkReg(6, conj | b);
        // Negative operand against positive
        checkReg(7, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        checkReg(8, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        checkReg(0, 32'd0);
        checkReg(9, a);
    endtask

    // Store followed by loads consumed by the very next instruction
    task automatic testMemory();
        logic [31:0] value;
        logic [31:0] base;
        value = signExt16(16'h0123);
        base  = 32'd8;
        clearProgram();
        emitI(opAddi, 10, 0, 16'h0123);
        emitI(opAddi, 11, 0, 16'd8);
        emitI(opSw, 10, 11, 16'd0);
        emitI(opLw, 12, 11, 16'd0);
        emitR(fnAdd, 13, 12, 10);
        emitI(opSw, 13, 11, 16'd4);
        emitI(opLw, 14, 11, 16'd4);
        // Load feeding store data
        emitI(opSw, 14, 11, 16'd8);
        emitSelfJump();
        executeProgram();
        checkReg(12, value);
        checkReg(13, value + value);
        checkReg(14, value + value);
        checkMem(dmemAw'(base >> 2), value);
        checkMem(dmemAw'((base + 4) >> 2), value + value);
        checkMem(dmemAw'((base + 8) >> 2), value + value);
    endtask

    // Shadow slots write markers that must never land
    task automatic testControlFlow();
        clearProgram();
        emitI(opAddi, 17, 0, 16'h0011);
        emitI(opAddi, 18, 0, 16'h0022);
        emitI(opAddi, 19, 0, 16'h0033);
        emitI(opAddi, 15, 0, 16'd5);
        emitI(opAddi, 16, 0, 16'd5);
        // Word 5 is taken to word 8
        emitI(opBeq, 16, 15, 16'd2);
        emitI(opAddi, 17, 0, 16'h07e1);
        emitI(opAddi, 18, 0, 16'h07e2);
        // Word 8 is not taken and would skip word 9
        emitI(opBeq, 17, 15, 16'd1);
        emitI(opAddi, 25, 0, 16'h0044);
        emitJ(12);
        emitI(opAddi, 19, 0, 16'h07e3);
        emitI(opAddi, 26, 0, 16'h0066);
        emitSelfJump();
        executeProgram();
        checkReg(17, 32'h11);
        checkReg(18, 32'h22);
        checkReg(19, 32'h33);
        checkReg(25, 32'h44);
        checkReg(26, 32'h66);
    endtask

    // Mid-run freeze must end with the same result as an unbroken run
    task automatic testFreeze();
        logic [31:0] heldPc;
        logic [31:0] heldReg;
        logic [31:0] expected;
        int unsigned bound;
        expected = 32'd1 << 12;
        clearProgram();
        emitI(opAddi, 1, 0, 16'd1);
        repeat (12) emitR(fnAdd, 1, 1, 1);
        emitI(opAddi, 11, 0, 16'd40);
        emitI(opSw, 1, 11, 16'd0);
        emitSelfJump();
        bound = 3 * prog.size() + 10;
        loadImage();
        @(posedge clk);
        debugRegAddr <= 5'd1;
        runCycles(8);
        freezeCore();
        @(negedge clk);
        heldPc  = pcOut;
        heldReg = debugRegData;
        repeat (freezeCycles) begin
            @(negedge clk);
            assert (pcOut === heldPc) else begin
                $display("[FAIL] pcOut while frozen: got 0x%h, expected 0x%h", pcOut, heldPc);
                abortRun();
            end
            assert (debugRegData === heldReg) else begin
                $display("[FAIL] debugRegData (r1) while frozen: got 0x%h, expected 0x%h",
                         debugRegData, heldReg);
                abortRun();
            end
        end
        @(posedge clk);
        stopDebug <= 1'b0;
        runCycles(bound);
        freezeCore();
        checkReg(1, expected);
        checkMem(dmemAw'(40 >> 2), expected);
    endtask

    // Random immediates sign-extended by the rules of ADDI
    task automatic testRandomOperands();
        logic [15:0] immA;
        logic [15:0] immB;
        logic [31:0] a;
        logic [31:0] b;
        for (int round = 0; round < 8; round++) begin
            immA = 16'($urandom());
            immB = 16'($urandom());
            a    = signExt16(immA);
            b    = signExt16(immB);
            clearProgram();
            emitI(opAddi, 1, 0, immA);
            emitI(opAddi, 2, 0, immB);
            emitR(fnAdd, 3, 1, 2);
            emitR(fnSub, 4, 1, 2);
            emitR(fnSlt, 5, 1, 2);
            emitSelfJump();
            executeProgram();
            checkReg(1, a);
            checkReg(2, b);
            checkReg(3, a + b);
            checkReg(4, a - b);
            checkReg(5, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        end
    endtask

    // Shorter image over a longer one with the old tail left in memory
    task automatic testReload();
        clearProgram();
        emitI(opAddi, 24, 0, 16'h0040);
        emitI(opAddi, 20, 0, 16'h00aa);
        emitI(opAddi, 21, 0, 16'h00bb);
        emitI(opAddi, 24, 24, 16'd1);
        emitSelfJump();
        executeProgram();
        checkReg(20, 32'haa);
        checkReg(24, 32'h41);
        clearProgram();
        emitI(opAddi, 20, 0, 16'h0155);
        emitI(opAddi, 22, 20, 16'd1);
        emitSelfJump();
        executeProgram();
        checkReg(20, 32'h155);
        checkReg(22, 32'h156);
        // Word 3 of the old image must stay unexecuted
        checkReg(24, 32'h41);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'hf28b_ad05));
        cycleCount     = 0;
        arstN          = 1'b0;
        loadProgram    = 1'b1;
        programWrite   = 1'b0;
        programAddress = '0;
        programData    = '0;
        stopDebug      = 1'b0;
        debugRegAddr   = '0;
        debugMemAddr   = '0;
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;
        testAluChain();
        testMemory();
        testControlFlow();
        testFreeze();
        testRandomOperands();
        testReload();
        $display("Test completed successfully");
        $finish;
    end

endmodule
